// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert --top-module rob_tb -f filelist.f -o rob_sim
	./obj_dir/rob_sim | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/rob_commit_fsm.sv
module rob_commit_fsm #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    rob_head_if.fsm                      head,
    // data cache handshake
    input  logic                         mem_resp,
    // register file commit
    output logic                         commit_valid,
    output rob_pkg::reg_idx_t            commit_rd,
    output logic [$clog2(ROB_DEPTH)-1:0] commit_tag,
    // redirect fetch
    output logic                         load_pc,
    // cache request, held until mem_resp
    output logic                         mem_read,
    output logic                         mem_write,
    output logic [$clog2(ROB_DEPTH)-1:0] mem_tag,
    output rob_pkg::reg_idx_t            store_src
);
    typedef enum logic {
        RUN,
        MEM_WAIT
    } state_t;

    state_t state;
    logic   head_ready;
    logic   head_is_mem;

    // head may act this cycle
    assign head_ready  = (state == RUN) && head.head_done && !head.empty;
    assign head_is_mem = (head.head_op == rob_pkg::OP_LD) || (head.head_op == rob_pkg::OP_ST);

    // alu and branch leave straight from RUN
    // loads and stores leave on the cache response
    assign head.retire = (head_ready && !head_is_mem) || ((state == MEM_WAIT) && mem_resp);
    // only a mispredicted branch squashes
    assign head.flush  = head_ready && (head.head_op == rob_pkg::OP_BR) && head.head_mispredict;

    always_ff @(posedge clk) begin
        // one-cycle pulses by default
        commit_valid <= 1'b0;
        load_pc      <= 1'b0;
        if (rst) begin
            state     <= RUN;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            case (state)
                RUN: begin
                    if (head_ready) begin
                        case (head.head_op)
                            rob_pkg::OP_ALU: begin
                                commit_valid <= 1'b1;
                                commit_rd    <= head.head_payload.rd;
                                commit_tag   <= head.head_tag;
                            end
                            rob_pkg::OP_BR: begin
                                load_pc <= 1'b1;
                            end
                            rob_pkg::OP_LD: begin
                                // address already sits with the cache, keyed by tag
                                state    <= MEM_WAIT;
                                mem_read <= 1'b1;
                                mem_tag  <= head.head_tag;
                            end
                            default: begin
                                // store, data register read as st_src
                                state     <= MEM_WAIT;
                                mem_write <= 1'b1;
                                mem_tag   <= head.head_tag;
                                store_src <= head.head_payload.st_src;
                            end
                        endcase
                    end
                end
                MEM_WAIT: begin
                    if (mem_resp) begin
                        state     <= RUN;
                        mem_read  <= 1'b0;
                        mem_write <= 1'b0;
                        // loads write back, stores only free the slot
                        if (mem_read) begin
                            commit_valid <= 1'b1;
                            commit_rd    <= head.head_payload.rd;
                            commit_tag   <= head.head_tag;
                        end
                    end
                end
                default: begin
                    state <= RUN;
                end
            endcase
        end
    end

    // one request kind at a time
    a_rd_wr_onehot: assert property (
        @(posedge clk) disable iff (rst)
        !(mem_read && mem_write)
    ) else $error("mem_read and mem_write both high");

endmodule

// File: design/rob_entry_store.sv
module rob_entry_store #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    // allocation from issue
    input  logic                         alloc_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    input  rob_pkg::op_t                 alloc_op,
    input  rob_pkg::rob_payload_u        alloc_payload,
    // completion from the cdb
    input  logic                         cdb_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] cdb_tag,
    input  logic                         cdb_mispredict,
    // head view toward the commit FSM
    rob_head_if.store                    head
);
    localparam int TAG_W = $clog2(ROB_DEPTH);

    // per-entry op, register field and mispredict flag
    rob_pkg::op_t          op_mem         [ROB_DEPTH];
    rob_pkg::rob_payload_u payload_mem    [ROB_DEPTH];
    logic                  mispredict_mem [ROB_DEPTH];

    // completion status, one bit per entry
    logic [ROB_DEPTH-1:0]  done;

    // distance of a tag from the head, used to tell live entries
    logic [TAG_W-1:0]      cdb_dist;
    logic [TAG_W-1:0]      live_dist;
    logic                  cdb_live;

    // op and register field written at the tail
    // mispredict bit lands together with done
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            op_mem[alloc_tag]      <= alloc_op;
            payload_mem[alloc_tag] <= alloc_payload;
        end
        if (cdb_valid) begin
            mispredict_mem[cdb_tag] <= cdb_mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= '0;
        end else if (head.flush) begin
            // wrong-path entries and a same-cycle alloc all vanish
            done <= '0;
        end else begin
            // fresh entry starts not done
            if (alloc_valid) begin
                done[alloc_tag] <= 1'b0;
            end
            if (cdb_valid) begin
                done[cdb_tag] <= 1'b1;
            end
            // retired slot is free again
            if (head.retire) begin
                done[head.head_tag] <= 1'b0;
            end
        end
    end

    // head read port
    assign head.head_op         = op_mem[head.head_tag];
    assign head.head_payload    = payload_mem[head.head_tag];
    assign head.head_mispredict = mispredict_mem[head.head_tag];
    // empty queue never shows a done head
    assign head.head_done       = done[head.head_tag] && !head.empty;

    // entry is live if it sits between head and tail
    // tail equal to head while not empty means full
    assign cdb_dist  = cdb_tag - head.head_tag;
    assign live_dist = alloc_tag - head.head_tag;
    assign cdb_live  = !head.empty && ((live_dist == '0) || (cdb_dist < live_dist));

    // a cdb broadcast only ever names an entry that is in flight
    a_cdb_targets_live: assert property (
        @(posedge clk) disable iff (rst)
        cdb_valid |-> cdb_live
    ) else $error("cdb completion for unallocated tag %0h", cdb_tag);

endmodule

// File: design/rob_head_if.sv
// head-of-queue bundle between entry storage and commit FSM
interface rob_head_if #(
    parameter int ROB_DEPTH = 8
);
    localparam int TAG_W = $clog2(ROB_DEPTH);

    // head entry contents, from the storage
    rob_pkg::op_t         head_op;
    rob_pkg::rob_payload_u head_payload;
    // done is already qualified by occupancy
    logic                 head_done;
    logic                 head_mispredict;

    // head pointer and empty flag, from the pointer block
    logic [TAG_W-1:0]     head_tag;
    logic                 empty;

    // pop head entry this cycle
    logic                 retire;
    // squash everything younger than the head, always with retire
    logic                 flush;

    // storage side reads the pointer and the controls
    modport store (
        output head_op, head_payload, head_done, head_mispredict,
        input  head_tag, empty, retire, flush
    );

    // commit side sees the whole head view and drives the controls
    modport fsm (
        input  head_op, head_payload, head_done, head_mispredict,
        input  head_tag, empty,
        output retire, flush
    );

endinterface

// File: design/rob_pkg.sv
package rob_pkg;

    // instruction kind held in each rob entry
    // alu ops and loads write a register, stores go to the cache,
    // branches only steer the fetch pc
    typedef enum logic [1:0] {
        OP_ALU = 2'b00,
        OP_LD  = 2'b01,
        OP_ST  = 2'b10,
        OP_BR  = 2'b11
    } op_t;

    // architectural register index, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // register field of an entry
    // one 5-bit word, read by op kind:
    //   alu / load -> destination register
    //   store      -> register holding the store data
    //   branch     -> unused
    typedef union packed {
        reg_idx_t rd;
        reg_idx_t st_src;
    } rob_payload_u;

endpackage

// File: design/rob_ptr_counter.sv
module rob_ptr_counter #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc_valid,
    input  logic                         retire,
    input  logic                         flush,
    // next free slot, handed out as the alloc tag
    output logic [$clog2(ROB_DEPTH)-1:0] tail,
    // oldest entry
    output logic [$clog2(ROB_DEPTH)-1:0] head_tag,
    output logic [$clog2(ROB_DEPTH):0]   count,
    output logic                         empty,
    // entries freed last cycle
    output logic [$clog2(ROB_DEPTH):0]   credit_return
);
    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [TAG_W:0] alloc_inc;
    logic [TAG_W:0] retire_dec;

    // one-bit events widened to count width
    assign alloc_inc  = {{TAG_W{1'b0}}, alloc_valid};
    assign retire_dec = {{TAG_W{1'b0}}, retire};

    always_ff @(posedge clk) begin
        if (rst) begin
            tail          <= '0;
            head_tag      <= '0;
            count         <= '0;
            credit_return <= '0;
        end else if (flush) begin
            // branch at head leaves, everything behind it is dropped
            head_tag      <= head_tag + 1'b1;
            tail          <= head_tag + 1'b1;
            count         <= '0;
            // all present entries plus a wrong-path alloc this cycle
            credit_return <= count + alloc_inc;
        end else begin
            if (alloc_valid) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head_tag <= head_tag + 1'b1;
            end
            count         <= count + alloc_inc - retire_dec;
            // at most one entry leaves outside a flush
            credit_return <= retire_dec;
        end
    end

    assign empty = (count == '0);

    // issuer holds no credit when full
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (rst)
        alloc_valid |-> (count != (TAG_W+1)'(ROB_DEPTH))
    ) else $error("allocation at full occupancy");

    // commit FSM only pops a real entry
    a_no_retire_empty: assert property (
        @(posedge clk) disable iff (rst)
        retire |-> !empty
    ) else $error("retire while rob is empty");

endmodule

// File: design/rob_top.sv
module rob_top #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    // issue side
    input  logic                         alloc_valid,
    input  rob_pkg::op_t                 alloc_op,
    input  rob_pkg::rob_payload_u        alloc_payload,
    output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    output logic [$clog2(ROB_DEPTH):0]   credit_return,
    // completion bus
    input  logic                         cdb_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] cdb_tag,
    input  logic                         cdb_mispredict,
    // commit side
    output logic                         commit_valid,
    output rob_pkg::reg_idx_t            commit_rd,
    output logic [$clog2(ROB_DEPTH)-1:0] commit_tag,
    output logic                         load_pc,
    // data cache side
    output logic                         mem_read,
    output logic                         mem_write,
    output logic [$clog2(ROB_DEPTH)-1:0] mem_tag,
    output rob_pkg::reg_idx_t            store_src,
    input  logic                         mem_resp
);
    rob_head_if #(.ROB_DEPTH(ROB_DEPTH)) head_bus ();

    // tail doubles as the tag handed to issue and the store write index
    // occupancy stays inside the pointer block
    rob_ptr_counter #(.ROB_DEPTH(ROB_DEPTH)) u_ptr (
        .clk           (clk),
        .rst           (rst),
        .alloc_valid   (alloc_valid),
        .retire        (head_bus.retire),
        .flush         (head_bus.flush),
        .tail          (alloc_tag),
        .head_tag      (head_bus.head_tag),
        .count         (),
        .empty         (head_bus.empty),
        .credit_return (credit_return)
    );

    rob_entry_store #(.ROB_DEPTH(ROB_DEPTH)) u_store (
        .clk            (clk),
        .rst            (rst),
        .alloc_valid    (alloc_valid),
        .alloc_tag      (alloc_tag),
        .alloc_op       (alloc_op),
        .alloc_payload  (alloc_payload),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_mispredict (cdb_mispredict),
        .head           (head_bus.store)
    );

    rob_commit_fsm #(.ROB_DEPTH(ROB_DEPTH)) u_fsm (
        .clk          (clk),
        .rst          (rst),
        .head         (head_bus.fsm),
        .mem_resp     (mem_resp),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .load_pc      (load_pc),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_tag      (mem_tag),
        .store_src    (store_src)
    );

endmodule

// File: filelist.f
design/rob_pkg.sv
design/rob_head_if.sv
design/rob_entry_store.sv
design/rob_ptr_counter.sv
design/rob_commit_fsm.sv
design/rob_top.sv
testbench/rob_checks.sv
testbench/rob_tb.sv

// File: testbench/rob_checks.sv
module rob_checks (
    input logic                  clk,
    input logic                  rst,
    input logic                  alloc_valid,
    input rob_pkg::op_t          alloc_op,
    input rob_pkg::rob_payload_u alloc_payload,
    input logic [2:0]            alloc_tag,
    input logic [3:0]            credit_return,
    input logic                  cdb_valid,
    input logic [2:0]            cdb_tag,
    input logic                  cdb_mispredict,
    input logic                  commit_valid,
    input rob_pkg::reg_idx_t     commit_rd,
    input logic [2:0]            commit_tag,
    input logic                  load_pc,
    input logic                  mem_read,
    input logic                  mem_write,
    input logic [2:0]            mem_tag,
    input rob_pkg::reg_idx_t     store_src,
    input logic                  mem_resp
);
    timeunit 1ns;
    timeprecision 1ps;

    // in-flight entries, oldest first
    logic [2:0]        q_tag [$];
    rob_pkg::op_t      q_op  [$];
    rob_pkg::reg_idx_t q_reg [$];
    logic              mispred [8];

    int         errors = 0;
    int         credits = 8;
    int         pending = 0;
    logic [2:0] exp_tail = '0;

    task automatic pop_front();
        void'(q_tag.pop_front());
        void'(q_op.pop_front());
        void'(q_reg.pop_front());
    endtask

    always @(posedge clk) begin
        if (rst) begin
            credits  = 8;
            exp_tail = '0;
            q_tag.delete();
            q_op.delete();
            q_reg.delete();
        end else begin
            credits = credits + int'(credit_return);
            // commit outputs reflect the edge before
            if (commit_valid) begin
                assert (q_tag.size() > 0 && q_op[0] != rob_pkg::OP_ST && q_op[0] != rob_pkg::OP_BR)
                else begin
                    $display("commit_valid with no ALU or load entry at the head");
                    errors++;
                end
                if (q_tag.size() > 0) begin
                    assert (commit_tag == q_tag[0]) else begin
                        $display("MISMATCH commit_tag got %h exp %h", commit_tag, q_tag[0]);
                        errors++;
                    end
                    assert (commit_rd == q_reg[0]) else begin
                        $display("MISMATCH commit_rd got %h exp %h", commit_rd, q_reg[0]);
                        errors++;
                    end
                    pop_front();
                end
                assert (credit_return == 4'd1) else begin
                    $display("MISMATCH credit_return got %h exp %h", credit_return, 4'd1);
                    errors++;
                end
            end else if (load_pc) begin
                assert (q_tag.size() > 0 && q_op[0] == rob_pkg::OP_BR) else begin
                    $display("load_pc with no branch at the head");
                    errors++;
                end
                if (q_tag.size() > 0 && mispred[q_tag[0]]) begin
                    // whole queue goes along with the wrong-path alloc
                    assert (int'(credit_return) == q_tag.size()) else begin
                        $display("MISMATCH credit_return got %h exp %h",
                                 credit_return, q_tag.size());
                        errors++;
                    end
                    exp_tail = q_tag[0] + 3'd1;
                    q_tag.delete();
                    q_op.delete();
                    q_reg.delete();
                end else if (q_tag.size() > 0) begin
                    pop_front();
                end
            end else if (credit_return != '0) begin
                // only a store leaves silently
                assert (q_tag.size() > 0 && q_op[0] == rob_pkg::OP_ST && credit_return == 4'd1)
                else begin
                    $display("credit returned without a store retiring");
                    errors++;
                end
                if (q_tag.size() > 0) begin
                    pop_front();
                end
            end
            if ((mem_read || mem_write) && q_tag.size() > 0) begin
                assert (mem_tag == q_tag[0]) else begin
                    $display("MISMATCH mem_tag got %h exp %h", mem_tag, q_tag[0]);
                    errors++;
                end
                assert (mem_read == (q_op[0] == rob_pkg::OP_LD)) else begin
                    $display("cache request kind does not match the head op");
                    errors++;
                end
                if (mem_write) begin
                    assert (store_src == q_reg[0]) else begin
                        $display("MISMATCH store_src got %h exp %h", store_src, q_reg[0]);
                        errors++;
                    end
                end
            end
            if (cdb_valid) begin
                mispred[cdb_tag] = cdb_mispredict;
            end
            if (alloc_valid) begin
                assert (credits > 0) else begin
                    $display("allocation without a credit");
                    errors++;
                end
                assert (alloc_tag == exp_tail) else begin
                    $display("MISMATCH alloc_tag got %h exp %h", alloc_tag, exp_tail);
                    errors++;
                end
                credits = credits - 1;
                mispred[alloc_tag] = 1'b0;
                q_tag.push_back(alloc_tag);
                q_op.push_back(alloc_op);
                q_reg.push_back(alloc_payload.rd);
                exp_tail = exp_tail + 3'd1;
            end
            assert (credits <= 8) else begin
                $display("credit counter above the rob depth");
                errors++;
            end
        end
        pending = q_tag.size();
    end

    // register commit and redirect never share a cycle
    a_commit_vs_redirect: assert property (
        @(posedge clk) disable iff (rst)
        !(commit_valid && load_pc)
    ) else begin
        $display("commit_valid and load_pc high together");
        errors++;
    end

    // cache request keeps its kind and tag until mem_resp is taken
    a_req_held: assert property (
        @(posedge clk) disable iff (rst)
        ((mem_read || mem_write) && !mem_resp) |=>
            ((mem_read || mem_write) && $stable(mem_read) && $stable(mem_tag))
    ) else begin
        $display("cache request dropped or changed before mem_resp");
        errors++;
    end

endmodule

// File: testbench/rob_tb.sv
module rob_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLE_LIMIT = 2000;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic                  alloc_valid = 1'b0;
    rob_pkg::op_t          alloc_op = rob_pkg::OP_ALU;
    rob_pkg::rob_payload_u alloc_payload = '0;
    logic [2:0]            alloc_tag;
    logic [3:0]            credit_return;
    logic                  cdb_valid = 1'b0;
    logic [2:0]            cdb_tag = '0;
    logic                  cdb_mispredict = 1'b0;
    logic                  commit_valid;
    rob_pkg::reg_idx_t     commit_rd;
    logic [2:0]            commit_tag;
    logic                  load_pc;
    logic                  mem_read;
    logic                  mem_write;
    logic [2:0]            mem_tag;
    rob_pkg::reg_idx_t     store_src;
    logic                  mem_resp = 1'b0;

    logic [31:0] rng = 32'h2f7b_119e;
    int          tb_errors = 0;
    int          tests_run = 0;
    int          cycle_count = 0;
    int          errs_before;

    rob_top #(.ROB_DEPTH(8)) DUT (.*);
    rob_checks u_checks (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int next_rand(input int range);
        rng = xorshift(rng);
        return int'(rng % range);
    endfunction

    // inputs change just after the edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic allocate(input rob_pkg::op_t op, input rob_pkg::reg_idx_t r);
        alloc_valid      = 1'b1;
        alloc_op         = op;
        alloc_payload.rd = r;
        tick();
        alloc_valid = 1'b0;
    endtask

    task automatic complete(input logic [2:0] tag, input logic mp);
        cdb_valid      = 1'b1;
        cdb_tag        = tag;
        cdb_mispredict = mp;
        tick();
        cdb_valid      = 1'b0;
        cdb_mispredict = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (u_checks.pending != 0 && n < 60) begin
            tick();
            n++;
        end
        if (u_checks.pending != 0) begin
            $display("rob did not drain, %0d entries left", u_checks.pending);
            tb_errors++;
        end
        tick();
    endtask

    // one load or store through a random cache delay
    task automatic mem_op(input rob_pkg::op_t op, input rob_pkg::reg_idx_t r);
        logic [2:0] t;
        int         n;
        t = alloc_tag;
        allocate(op, r);
        complete(t, 1'b0);
        n = 0;
        while (!(mem_read || mem_write) && n < 20) begin
            tick();
            n++;
        end
        if (!(mem_read || mem_write)) begin
            $display("no cache request for tag %0h", t);
            tb_errors++;
        end
        repeat (next_rand(6)) tick();
        mem_resp = 1'b1;
        tick();
        mem_resp = 1'b0;
        drain();
    endtask

    task automatic report(input string name);
        tests_run++;
        if (tb_errors + u_checks.errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: failed", tests_run, name);
        end
        errs_before = tb_errors + u_checks.errors;
    endtask

    initial begin
        logic [2:0] order [8];
        logic [2:0] tmp;
        logic [2:0] br;
        int         j;
        errs_before = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        tick();

        // test 1, reset state and eight allocations
        assert (!commit_valid && !load_pc && !mem_read && !mem_write && credit_return == '0)
        else begin
            $display("outputs not low after reset");
            tb_errors++;
        end
        for (int i = 0; i < 8; i++) begin
            allocate(rob_pkg::OP_ALU, rob_pkg::reg_idx_t'(next_rand(32)));
        end
        assert (u_checks.credits == 0) else begin
            $display("MISMATCH credits got %h exp %h", u_checks.credits, 0);
            tb_errors++;
        end
        report("fill");

        // test 2, shuffled completion order
        for (int i = 0; i < 8; i++) begin
            order[i] = 3'(i);
        end
        for (int i = 7; i > 0; i--) begin
            j        = next_rand(i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 8; i++) begin
            complete(order[i], 1'b0);
        end
        drain();
        assert (u_checks.credits == 8) else begin
            $display("MISMATCH credits got %h exp %h", u_checks.credits, 8);
            tb_errors++;
        end
        report("in-order commit");

        // test 3 and 4, cache handshakes
        repeat (3) mem_op(rob_pkg::OP_LD, rob_pkg::reg_idx_t'(next_rand(32)));
        report("load");
        repeat (3) mem_op(rob_pkg::OP_ST, rob_pkg::reg_idx_t'(next_rand(32)));
        report("store");

        // test 5, branch flush with a wrong-path alloc on the flush edge
        br = alloc_tag;
        allocate(rob_pkg::OP_BR, 5'd0);
        allocate(rob_pkg::OP_ALU, 5'd3);
        allocate(rob_pkg::OP_ALU, 5'd4);
        complete(br + 3'd2, 1'b0);
        complete(br, 1'b1);
        allocate(rob_pkg::OP_ALU, 5'd7);
        tick();
        assert (alloc_tag == br + 3'd1) else begin
            $display("MISMATCH alloc_tag got %h exp %h", alloc_tag, br + 3'd1);
            tb_errors++;
        end
        allocate(rob_pkg::OP_ALU, 5'd9);
        complete(br + 3'd1, 1'b0);
        drain();
        assert (u_checks.credits == 8) else begin
            $display("MISMATCH credits got %h exp %h", u_checks.credits, 8);
            tb_errors++;
        end
        report("mispredict flush");

        $display("tests %0d, errors %0d", tests_run, tb_errors + u_checks.errors);
        if (tb_errors + u_checks.errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // hard stop well beyond the summed test length
    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing", cycle_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
